// ==== Makefile ====
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  --top-module sldu_tb -f files.f -Mdir obj_dir -o sldu_sim
	./obj_dir/sldu_sim | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== bench/sldu_assertions.sv ====
// Slide unit port assertions
`timescale 1ns/1ps
`default_nettype none

module sldu_assertions #(
  parameter int unsigned NrLanes = 4
) (
  input  wire logic                              clk_i,
  input  wire logic                              rst_ni,
  input  wire logic [NrLanes-1:0]                sldu_result_req_o,
  input  sldu_pkg::lane_payload_t [NrLanes-1:0]  sldu_result_o,
  input  wire logic [NrLanes-1:0]                sldu_result_gnt_i,
  input  sldu_pkg::pe_resp_t                     pe_resp_o
);

  // Failed assertions, read by the testbench
  int unsigned fail_cnt = 0;

  for (genvar l = 0; l < NrLanes; l++) begin : g_lane
    // Waiting request keeps its payload until granted
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      sldu_result_req_o[l] && !sldu_result_gnt_i[l] |=>
        sldu_result_req_o[l] && $stable(sldu_result_o[l]))
    else begin
      fail_cnt++;
      $error("lane %0d result changed before its grant", l);
    end
  end

  for (genvar i = 0; i < sldu_pkg::NrVinsn; i++) begin : g_done
    // Done is a single-cycle pulse
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      pe_resp_o.vinsn_done[i] |=> !pe_resp_o.vinsn_done[i])
    else begin
      fail_cnt++;
      $error("done bit %0d high for two cycles", i);
    end
  end

endmodule

bind sldu_top sldu_assertions #(.NrLanes(NrLanes)) u_assertions (
  .clk_i(clk_i), .rst_ni(rst_ni), .sldu_result_req_o(sldu_result_req_o),
  .sldu_result_o(sldu_result_o), .sldu_result_gnt_i(sldu_result_gnt_i), .pe_resp_o(pe_resp_o)
);

`default_nettype wire

// ==== bench/sldu_tb.sv ====
// Slide unit testbench
`timescale 1ns/1ps
`default_nettype none

module sldu_tb;

  localparam int unsigned NrLanes    = 4;
  localparam int unsigned WordBytes  = NrLanes * sldu_pkg::LaneBytes;
  localparam int unsigned DriveDelay = 2;
  localparam int unsigned NumRandom  = 16;
  // Directed plus random instructions, each at most one register of words
  localparam int unsigned NumInsn    = 12 + NumRandom;
  localparam int unsigned InsnCycles = sldu_pkg::RegWords * 48;
  localparam int unsigned MaxCycles  = NumInsn * InsnCycles + 20;

  typedef sldu_pkg::elen_t [NrLanes-1:0] word_t;

  logic                                  clk_i;
  logic                                  rst_ni;
  sldu_pkg::pe_req_t                     pe_req_i;
  logic                                  pe_req_valid_i;
  logic                                  pe_req_ready_o;
  sldu_pkg::pe_resp_t                    pe_resp_o;
  word_t                                 sldu_operand_i;
  logic [NrLanes-1:0]                    sldu_operand_valid_i;
  logic                                  sldu_operand_ready_o;
  logic [NrLanes-1:0]                    sldu_result_req_o;
  sldu_pkg::lane_payload_t [NrLanes-1:0] sldu_result_o;
  logic [NrLanes-1:0]                    sldu_result_gnt_i;

  // Lane model and scoreboard state
  word_t                   operand_q[$];
  sldu_pkg::lane_payload_t expect_q[NrLanes][$];
  sldu_pkg::vid_t          done_q[$];
  string                   test_name;
  logic                    operand_fire = 1'b0;
  int unsigned             grant_pct = 70;
  int unsigned             cycle_cnt = 0;

  sldu_top #(.NrLanes(NrLanes)) DUT (.*);

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  task automatic abort_run();
    $display(">>> FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_payload(input sldu_pkg::lane_payload_t exp,
                               input sldu_pkg::lane_payload_t act, input int unsigned lane);
    string exp_s;
    string act_s;
    if (act !== exp) begin
      exp_s = $sformatf("id=%0d addr=%0h wdata=%h be=%b", exp.id, exp.addr, exp.wdata, exp.be);
      act_s = $sformatf("id=%0d addr=%0h wdata=%h be=%b", act.id, act.addr, act.wdata, act.be);
      $display("mismatch %s lane %0d expected %s actual %s", test_name, lane, exp_s, act_s);
      abort_run();
    end
  endtask

  task automatic check_done(input sldu_pkg::vid_t exp, input sldu_pkg::vid_t act);
    if (act !== exp) begin
      $display("mismatch %s done id expected %0d actual %0d", test_name, exp, act);
      abort_run();
    end
  endtask

  // Source register fill, every address bit matters
  function automatic logic [7:0] src_byte(input int unsigned tag, input int unsigned idx);
    return 8'((idx * 29) ^ (idx >> 8) ^ (tag * 83) ^ 32'h5a);
  endfunction

  function automatic int unsigned total_bytes(input sldu_pkg::pe_req_t req);
    return 32'(req.vl) << int'(req.sew);
  endfunction

  function automatic int unsigned offset_bytes(input sldu_pkg::pe_req_t req);
    return 32'(req.stride) << int'(req.sew);
  endfunction

  // Emitted words, up skips whole words below the offset
  function automatic int unsigned num_words(input sldu_pkg::pe_req_t req);
    int unsigned n;
    int unsigned s;
    n = total_bytes(req);
    s = offset_bytes(req);
    if (req.op == sldu_pkg::SLIDE_UP) return (n - 1) / WordBytes - s / WordBytes + 1;
    else return (n - s + WordBytes - 1) / WordBytes;
  endfunction

  // Reference model of one lane of the k-th emitted word
  function automatic sldu_pkg::lane_payload_t expected_lane(input sldu_pkg::pe_req_t req,
      input int unsigned tag, input int unsigned k, input int unsigned l);
    sldu_pkg::lane_payload_t p;
    int unsigned n;
    int unsigned s;
    int unsigned base;
    int unsigned d;
    n = total_bytes(req);
    s = offset_bytes(req);
    base = (req.op == sldu_pkg::SLIDE_UP) ? s / WordBytes : 0;
    p = '0;
    p.id = req.id;
    p.addr = sldu_pkg::vaddr_t'(32'(req.vd) * sldu_pkg::RegWords + base + k);
    for (int unsigned j = 0; j < sldu_pkg::LaneBytes; j++) begin
      d = (base + k) * WordBytes + l * sldu_pkg::LaneBytes + j;
      if (req.op == sldu_pkg::SLIDE_UP && d >= s && d < n) begin
        p.wdata[8*j +: 8] = src_byte(tag, d - s);
        p.be[j] = 1'b1;
      end else if (req.op == sldu_pkg::SLIDE_DOWN && d + s < n) begin
        p.wdata[8*j +: 8] = src_byte(tag, d + s);
        p.be[j] = 1'b1;
      end
    end
    return p;
  endfunction

  function automatic sldu_pkg::pe_req_t make_req(input int unsigned id,
      input sldu_pkg::slide_op_e op, input int unsigned vd, input int unsigned vl,
      input int unsigned stride, input int unsigned sew);
    sldu_pkg::pe_req_t r;
    r.id     = sldu_pkg::vid_t'(id);
    r.op     = op;
    r.vd     = 5'(vd);
    r.vl     = sldu_pkg::vlen_t'(vl);
    r.stride = sldu_pkg::vlen_t'(stride);
    r.sew    = sldu_pkg::sew_e'(2'(sew));
    return r;
  endfunction

  // Queue source words and expected results, then hand the request over
  task automatic send_req(input sldu_pkg::pe_req_t req, input int unsigned tag);
    int unsigned n;
    int unsigned s;
    int unsigned first;
    int unsigned count;
    word_t       word;
    @(negedge clk_i);
    n = total_bytes(req);
    s = offset_bytes(req);
    first = (req.op == sldu_pkg::SLIDE_UP) ? 0 : s / WordBytes;
    count = (req.op == sldu_pkg::SLIDE_UP) ? (n - s + WordBytes - 1) / WordBytes
                                           : (n - 1) / WordBytes - first + 1;
    for (int unsigned w = 0; w < count; w++) begin
      for (int unsigned b = 0; b < WordBytes; b++) begin
        word[b / 8][8*(b % 8) +: 8] = src_byte(tag, (first + w) * WordBytes + b);
      end
      operand_q.push_back(word);
    end
    for (int unsigned k = 0; k < num_words(req); k++) begin
      for (int unsigned l = 0; l < NrLanes; l++) begin
        expect_q[l].push_back(expected_lane(req, tag, k, l));
      end
    end
    done_q.push_back(req.id);
    @(posedge clk_i);
    #DriveDelay;
    pe_req_i       = req;
    pe_req_valid_i = 1'b1;
    @(negedge clk_i);
    while (!pe_req_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    #DriveDelay;
    pe_req_valid_i = 1'b0;
  endtask

  task automatic wait_idle();
    while (done_q.size() != 0) @(negedge clk_i);
    for (int l = 0; l < NrLanes; l++) begin
      if (expect_q[l].size() != 0) begin
        $display("%s lane %0d still owes result words after the done pulse", test_name, l);
        abort_run();
      end
    end
  endtask

  // Lane and grant model, inputs change just after the edge
  always @(posedge clk_i) begin
    #DriveDelay;
    if (operand_fire) operand_q.delete(0);
    if (operand_q.size() != 0) begin
      sldu_operand_i = operand_q[0];
      for (int l = 0; l < NrLanes; l++) sldu_operand_valid_i[l] = ($urandom % 100) < 90;
    end else begin
      sldu_operand_i       = '0;
      sldu_operand_valid_i = '0;
    end
    for (int l = 0; l < NrLanes; l++) sldu_result_gnt_i[l] = ($urandom % 100) < grant_pct;
  end

  // Handshakes are sampled mid-cycle where every output is settled
  always @(negedge clk_i) begin : monitor
    sldu_pkg::vid_t done_id;
    done_id      = '0;
    operand_fire = 1'b0;
    if (rst_ni) begin
      if (DUT.u_assertions.fail_cnt != 0) begin
        $display("a bound assertion on the DUT ports failed");
        abort_run();
      end
      if (sldu_operand_ready_o && operand_q.size() == 0) begin
        $display("%s DUT consumed a source word that was never presented", test_name);
        abort_run();
      end
      operand_fire = sldu_operand_ready_o;
      for (int l = 0; l < NrLanes; l++) begin
        if (sldu_result_req_o[l] && sldu_result_gnt_i[l]) begin
          if (expect_q[l].size() == 0) begin
            $display("%s lane %0d delivered a word that was not expected", test_name, l);
            abort_run();
          end else begin
            check_payload(expect_q[l].pop_front(), sldu_result_o[l], l);
          end
        end
      end
      if (pe_resp_o.vinsn_done != '0) begin
        if ($countones(pe_resp_o.vinsn_done) != 1 || done_q.size() == 0) begin
          $display("%s unexpected done pulse %b", test_name, pe_resp_o.vinsn_done);
          abort_run();
        end else begin
          for (int i = 0; i < sldu_pkg::NrVinsn; i++) begin
            if (pe_resp_o.vinsn_done[i]) done_id = sldu_pkg::vid_t'(i);
          end
          check_done(done_q.pop_front(), done_id);
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > MaxCycles) begin
      $display("run did not finish within %0d cycles", MaxCycles);
      abort_run();
    end
  end

  initial begin : main
    int unsigned sew_v;
    int unsigned n_el;
    void'($urandom(86280));
    pe_req_i             = '0;
    pe_req_valid_i       = 1'b0;
    sldu_operand_i       = '0;
    sldu_operand_valid_i = '0;
    sldu_result_gnt_i    = '0;
    rst_ni               = 1'b0;
    test_name            = "reset";
    repeat (5) @(posedge clk_i);
    #DriveDelay;
    rst_ni = 1'b1;
    @(negedge clk_i);
    if (!pe_req_ready_o || sldu_operand_ready_o || sldu_result_req_o != '0 ||
        pe_resp_o != '0) begin
      $display("outputs are not inactive after reset");
      abort_run();
    end

    test_name = "slide_up_small";
    send_req(make_req(1, sldu_pkg::SLIDE_UP, 2, 100, 5, 0), 1);
    wait_idle();

    // Offset past one word drops the leading source word
    test_name = "slide_down_large";
    send_req(make_req(2, sldu_pkg::SLIDE_DOWN, 4, 150, 45, 0), 2);
    wait_idle();

    for (int unsigned s = 0; s < 4; s++) begin
      test_name = $sformatf("sew_%0d", 8 << s);
      send_req(make_req(3, sldu_pkg::SLIDE_UP, 6, 240 >> s, 9 + s, s), 10 + s);
      send_req(make_req(4, sldu_pkg::SLIDE_DOWN, 7, 240 >> s, 9 + s, s), 20 + s);
      wait_idle();
    end

    test_name = "random_grants";
    grant_pct = 35;
    for (int unsigned i = 0; i < NumRandom; i++) begin
      sew_v = $urandom % 4;
      n_el  = 1 + $urandom % (512 >> sew_v);
      send_req(make_req(i, sldu_pkg::slide_op_e'(1'($urandom % 2)), $urandom % 32, n_el,
                        $urandom % n_el, sew_v), 100 + i);
    end
    wait_idle();

    // Long first instruction keeps both entries busy
    test_name = "two_queued";
    grant_pct = 50;
    send_req(make_req(6, sldu_pkg::SLIDE_UP, 10, 500, 40, 0), 40);
    send_req(make_req(7, sldu_pkg::SLIDE_DOWN, 12, 120, 3, 2), 41);
    @(negedge clk_i);
    if (pe_req_ready_o) begin
      $display("request ready stayed high with two instructions queued");
      abort_run();
    end
    wait_idle();

    if (operand_q.size() == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      $display("source words left over at the end of the run");
      abort_run();
    end
  end

endmodule

`default_nettype wire

// ==== files.f ====
src/sldu_pkg.sv
src/sldu_insn_queue.sv
src/sldu_byte_counter.sv
src/sldu_slide_fsm.sv
src/sldu_byte_shifter.sv
src/sldu_result_queue.sv
src/sldu_top.sv
bench/sldu_assertions.sv
bench/sldu_tb.sv

// ==== src/sldu_byte_counter.sv ====
// Issue and commit byte counters
`timescale 1ns/1ps
`default_nettype none

module sldu_byte_counter #(
  parameter int unsigned NrLanes = 4
) (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  wire logic              issue_load_i,
  input  sldu_pkg::pe_req_t      issue_req_i,
  input  sldu_pkg::vlen_t        chunk_bytes_i,
  output sldu_pkg::vlen_t        issue_rem_o,
  input  wire logic              commit_load_i,
  input  sldu_pkg::pe_req_t      commit_req_i,
  input  wire logic              word_retired_i,
  output logic                   commit_done_o
);

  localparam int unsigned WordBytes = NrLanes * sldu_pkg::LaneBytes;
  localparam int unsigned WIdx      = $clog2(WordBytes);

  sldu_pkg::vlen_t issue_rem_q, commit_rem_q;
  sldu_pkg::vlen_t issue_init, commit_init, commit_n, commit_skip;
  sldu_pkg::vlen_t issue_cur, commit_cur;

  // Source bytes left to copy, stride already in bytes
  assign issue_init = (issue_req_i.vl << int'(issue_req_i.sew)) - issue_req_i.stride;

  // Slide up never touches the whole words below the offset
  assign commit_n    = commit_req_i.vl << int'(commit_req_i.sew);
  assign commit_skip = (commit_req_i.stride >> WIdx) << WIdx;
  assign commit_init = (commit_req_i.op == sldu_pkg::SLIDE_UP) ?
                       commit_n - commit_skip : commit_n - commit_req_i.stride;

  // A zero count means no instruction is loaded yet
  assign issue_cur  = (issue_load_i && issue_rem_q == '0) ? issue_init : issue_rem_q;
  assign commit_cur = (commit_load_i && commit_rem_q == '0) ? commit_init : commit_rem_q;

  assign issue_rem_o = issue_rem_q;

  // Last word leaves when at most one word of bytes remains
  assign commit_done_o = word_retired_i && (commit_cur != '0) &&
                         (commit_cur <= sldu_pkg::vlen_t'(WordBytes));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issue_rem_q  <= '0;
      commit_rem_q <= '0;
    end else begin
      issue_rem_q <= issue_cur - chunk_bytes_i;
      if (word_retired_i) begin
        // Saturate on a partial last word
        commit_rem_q <= (commit_cur > sldu_pkg::vlen_t'(WordBytes)) ?
                        commit_cur - sldu_pkg::vlen_t'(WordBytes) : '0;
      end else begin
        commit_rem_q <= commit_cur;
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/sldu_byte_shifter.sv ====
// Slide byte crossbar
`timescale 1ns/1ps
`default_nettype none

module sldu_byte_shifter #(
  parameter int unsigned NrLanes = 4,
  localparam int unsigned WordBytes = NrLanes * sldu_pkg::LaneBytes,
  localparam int unsigned PntW      = $clog2(WordBytes) + 1
) (
  input  sldu_pkg::elen_t [NrLanes-1:0]         operand_i,
  input  wire logic [PntW-1:0]                  in_pnt_i,
  input  wire logic [PntW-1:0]                  out_pnt_i,
  input  wire logic [PntW-1:0]                  byte_count_i,
  input  sldu_pkg::pe_req_t                     issue_req_i,
  input  sldu_pkg::vaddr_t                      word_index_i,
  output sldu_pkg::lane_payload_t [NrLanes-1:0] payload_o
);

  localparam int unsigned WIdx = $clog2(WordBytes);

  logic [NrLanes*sldu_pkg::ElenW-1:0] operand_flat;
  sldu_pkg::vaddr_t                   base_addr;

  assign operand_flat = operand_i;

  // Slide up starts past the skipped whole words
  assign base_addr = sldu_pkg::vaddr_t'(issue_req_i.vd) * sldu_pkg::vaddr_t'(sldu_pkg::RegWords)
                   + ((issue_req_i.op == sldu_pkg::SLIDE_UP) ?
                      sldu_pkg::vaddr_t'(issue_req_i.stride >> WIdx) : '0)
                   + word_index_i;

  always_comb begin
    payload_o = '0;
    for (int o = 0; o < WordBytes; o++) begin
      automatic int rel = o - int'(out_pnt_i);
      automatic int src = int'(in_pnt_i) + rel;
      // Byte lies inside this cycle's chunk window
      if (rel >= 0 && rel < int'(byte_count_i) && src < WordBytes) begin
        payload_o[o / 8].wdata[8*(o % 8) +: 8] = operand_flat[8*src +: 8];
        payload_o[o / 8].be[o % 8]             = 1'b1;
      end
    end
    // Every lane gets the word address, even with no bytes
    for (int l = 0; l < NrLanes; l++) begin
      payload_o[l].id   = issue_req_i.id;
      payload_o[l].addr = base_addr;
    end
  end

endmodule

`default_nettype wire

// ==== src/sldu_insn_queue.sv ====
// Slide instruction queue
`timescale 1ns/1ps
`default_nettype none

module sldu_insn_queue (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  sldu_pkg::pe_req_t      req_i,
  input  wire logic              req_valid_i,
  output logic                   req_ready_o,
  output sldu_pkg::pe_req_t      issue_req_o,
  output logic                   issue_valid_o,
  input  wire logic              issue_done_i,
  output sldu_pkg::pe_req_t      commit_req_o,
  output logic                   commit_valid_o,
  input  wire logic              commit_done_i
);

  // Two entries, depth fixed by the issue/commit overlap
  sldu_pkg::pe_req_t [1:0] entry_q;

  // Single-bit pointers wrap naturally over two entries
  logic       accept_pnt_q;
  logic       issue_pnt_q;
  logic       commit_pnt_q;
  logic [1:0] issue_cnt_q;
  logic [1:0] commit_cnt_q;

  logic accept;

  // Commit count covers every entry still in flight
  assign req_ready_o = (commit_cnt_q != 2'd2);
  assign accept      = req_valid_i && req_ready_o;

  assign issue_req_o    = entry_q[issue_pnt_q];
  assign issue_valid_o  = (issue_cnt_q != 2'd0);
  assign commit_req_o   = entry_q[commit_pnt_q];
  assign commit_valid_o = (commit_cnt_q != 2'd0);

  // Entry store, stride kept in bytes from here on
  always_ff @(posedge clk_i) begin
    if (accept) begin
      entry_q[accept_pnt_q]        <= req_i;
      entry_q[accept_pnt_q].stride <= req_i.stride << int'(req_i.sew);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= 1'b0;
      issue_pnt_q  <= 1'b0;
      commit_pnt_q <= 1'b0;
      issue_cnt_q  <= 2'd0;
      commit_cnt_q <= 2'd0;
    end else begin
      if (accept) begin
        accept_pnt_q <= ~accept_pnt_q;
      end
      if (issue_done_i) begin
        issue_pnt_q <= ~issue_pnt_q;
      end
      if (commit_done_i) begin
        commit_pnt_q <= ~commit_pnt_q;
      end
      // Net change when accept and retire coincide
      issue_cnt_q  <= issue_cnt_q + 2'(accept) - 2'(issue_done_i);
      commit_cnt_q <= commit_cnt_q + 2'(accept) - 2'(commit_done_i);
    end
  end

endmodule

`default_nettype wire

// ==== src/sldu_pkg.sv ====
// Slide unit shared definitions
`default_nettype none

package sldu_pkg;

  // Lane word geometry
  localparam int unsigned LaneBytes = 8;
  localparam int unsigned ElenW     = 64;
  // Byte counts and pointers
  localparam int unsigned VlenW     = 16;
  // Instruction ids and register size in result words
  localparam int unsigned NrVinsn   = 8;
  localparam int unsigned RegWords  = 16;

  typedef logic [$clog2(NrVinsn)-1:0] vid_t;
  typedef logic [ElenW-1:0]           elen_t;
  typedef logic [LaneBytes-1:0]       strb_t;
  typedef logic [VlenW-1:0]           vlen_t;
  typedef logic [11:0]                vaddr_t;

  // Element width, log2 of the element size in bytes
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } sew_e;

  typedef enum logic {
    SLIDE_UP   = 1'b0,
    SLIDE_DOWN = 1'b1
  } slide_op_e;

  // Request from the sequencer, vl and stride in elements
  typedef struct packed {
    vid_t      id;
    slide_op_e op;
    logic [4:0] vd;
    vlen_t     vl;
    vlen_t     stride;
    sew_e      sew;
  } pe_req_t;

  typedef struct packed {
    logic [NrVinsn-1:0] vinsn_done;
  } pe_resp_t;

  // One lane's share of a result word
  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    elen_t  wdata;
    strb_t  be;
  } lane_payload_t;

endpackage

`default_nettype wire

// ==== src/sldu_result_queue.sv ====
// Per-lane result queue
`timescale 1ns/1ps
`default_nettype none

module sldu_result_queue #(
  parameter int unsigned NrLanes = 4,
  parameter type         payload_t = sldu_pkg::lane_payload_t
) (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  input  wire logic                push_i,
  input  payload_t [NrLanes-1:0]   payload_i,
  output logic                     full_o,
  output logic [NrLanes-1:0]       req_o,
  output payload_t [NrLanes-1:0]   data_o,
  input  wire logic [NrLanes-1:0]  gnt_i,
  output logic                     word_retired_o
);

  payload_t [1:0][NrLanes-1:0] ring_q, ring_d;
  logic     [1:0][NrLanes-1:0] valid_q, valid_d;
  logic                        wr_pnt_q, rd_pnt_q;
  logic [1:0]                  cnt_q;
  logic                        any_be;

  assign full_o = (cnt_q == 2'd2);
  assign req_o  = valid_q[rd_pnt_q];
  assign data_o = ring_q[rd_pnt_q];

  always_comb begin
    ring_d  = ring_q;
    valid_d = valid_q;
    any_be  = 1'b0;
    for (int l = 0; l < NrLanes; l++) begin
      any_be = any_be | (|payload_i[l].be);
    end
    // Chunks accumulate into the open write entry
    if (any_be) begin
      for (int l = 0; l < NrLanes; l++) begin
        ring_d[wr_pnt_q][l].id   = payload_i[l].id;
        ring_d[wr_pnt_q][l].addr = payload_i[l].addr;
        for (int b = 0; b < sldu_pkg::LaneBytes; b++) begin
          if (payload_i[l].be[b]) begin
            ring_d[wr_pnt_q][l].wdata[8*b +: 8] = payload_i[l].wdata[8*b +: 8];
            ring_d[wr_pnt_q][l].be[b]           = 1'b1;
          end
        end
      end
    end
    if (push_i) begin
      valid_d[wr_pnt_q] = '1;
    end
    // Granted lanes drop out and leave a clean slot
    for (int l = 0; l < NrLanes; l++) begin
      if (gnt_i[l] && valid_q[rd_pnt_q][l]) begin
        valid_d[rd_pnt_q][l] = 1'b0;
        ring_d[rd_pnt_q][l]  = '0;
      end
    end
  end

  // Head word done once no lane still waits
  assign word_retired_o = (cnt_q != 2'd0) && (valid_d[rd_pnt_q] == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ring_q   <= '0;
      valid_q  <= '0;
      wr_pnt_q <= 1'b0;
      rd_pnt_q <= 1'b0;
      cnt_q    <= 2'd0;
    end else begin
      ring_q   <= ring_d;
      valid_q  <= valid_d;
      wr_pnt_q <= wr_pnt_q ^ push_i;
      rd_pnt_q <= rd_pnt_q ^ word_retired_o;
      cnt_q    <= cnt_q + 2'(push_i) - 2'(word_retired_o);
    end
  end

endmodule

`default_nettype wire

// ==== src/sldu_slide_fsm.sv ====
// Slide control state machine
`timescale 1ns/1ps
`default_nettype none

module sldu_slide_fsm #(
  parameter int unsigned NrLanes = 4,
  localparam int unsigned WordBytes = NrLanes * sldu_pkg::LaneBytes,
  localparam int unsigned PntW      = $clog2(WordBytes) + 1
) (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  input  sldu_pkg::pe_req_t        issue_req_i,
  input  wire logic                issue_valid_i,
  input  sldu_pkg::vlen_t          issue_rem_i,
  input  wire logic [NrLanes-1:0]  operand_valid_i,
  input  wire logic                rq_full_i,
  output logic [PntW-1:0]          in_pnt_o,
  output logic [PntW-1:0]          out_pnt_o,
  output logic [PntW-1:0]          byte_count_o,
  output logic                     chunk_o,
  output logic                     operand_ready_o,
  output logic                     push_o,
  output logic                     issue_done_o
);

  typedef enum logic {
    SLIDE_IDLE,
    SLIDE_RUN
  } state_e;

  localparam logic [PntW-1:0] FullWord = PntW'(WordBytes);

  state_e          state_q, state_d;
  logic [PntW-1:0] in_pnt_q, in_pnt_d;
  logic [PntW-1:0] out_pnt_q, out_pnt_d;
  logic [PntW-1:0] in_left, out_left, step;
  logic [PntW-1:0] offset;
  logic            last;

  // Offset of the slide within one word
  assign offset = {1'b0, issue_req_i.stride[PntW-2:0]};

  // Chunk is bounded by both word ends and the bytes left
  assign in_left  = FullWord - in_pnt_q;
  assign out_left = FullWord - out_pnt_q;
  always_comb begin
    step = (in_left < out_left) ? in_left : out_left;
    if (issue_rem_i < sldu_pkg::vlen_t'(step)) begin
      step = PntW'(issue_rem_i);
    end
  end
  assign last = (issue_rem_i <= sldu_pkg::vlen_t'(step));

  assign in_pnt_o     = in_pnt_q;
  assign out_pnt_o    = out_pnt_q;
  assign byte_count_o = step;
  // Move only with every lane valid and room downstream
  assign chunk_o      = (state_q == SLIDE_RUN) && (&operand_valid_i) && !rq_full_i;

  always_comb begin
    state_d         = state_q;
    in_pnt_d        = in_pnt_q;
    out_pnt_d       = out_pnt_q;
    operand_ready_o = 1'b0;
    push_o          = 1'b0;
    issue_done_o    = 1'b0;
    unique case (state_q)
      SLIDE_IDLE: begin
        if (issue_valid_i) begin
          state_d = SLIDE_RUN;
          // Up writes at the offset, down reads from it
          in_pnt_d  = (issue_req_i.op == sldu_pkg::SLIDE_DOWN) ? offset : '0;
          out_pnt_d = (issue_req_i.op == sldu_pkg::SLIDE_UP) ? offset : '0;
        end
      end
      SLIDE_RUN: begin
        if (chunk_o) begin
          in_pnt_d  = in_pnt_q + step;
          out_pnt_d = out_pnt_q + step;
          // Source word used up
          if (in_pnt_d == FullWord || last) begin
            in_pnt_d        = '0;
            operand_ready_o = 1'b1;
          end
          // Result word filled
          if (out_pnt_d == FullWord || last) begin
            out_pnt_d = '0;
            push_o    = 1'b1;
          end
          if (last) begin
            state_d      = SLIDE_IDLE;
            issue_done_o = 1'b1;
          end
        end
      end
      default: state_d = SLIDE_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= SLIDE_IDLE;
      in_pnt_q  <= '0;
      out_pnt_q <= '0;
    end else begin
      state_q   <= state_d;
      in_pnt_q  <= in_pnt_d;
      out_pnt_q <= out_pnt_d;
    end
  end

endmodule

`default_nettype wire

// ==== src/sldu_top.sv ====
// Vector slide unit
`timescale 1ns/1ps
`default_nettype none

module sldu_top #(
  parameter int unsigned NrLanes = 4
) (
  input  wire logic                              clk_i,
  input  wire logic                              rst_ni,
  input  sldu_pkg::pe_req_t                      pe_req_i,
  input  wire logic                              pe_req_valid_i,
  output logic                                   pe_req_ready_o,
  output sldu_pkg::pe_resp_t                     pe_resp_o,
  input  sldu_pkg::elen_t [NrLanes-1:0]          sldu_operand_i,
  input  wire logic [NrLanes-1:0]                sldu_operand_valid_i,
  output logic                                   sldu_operand_ready_o,
  output logic [NrLanes-1:0]                     sldu_result_req_o,
  output sldu_pkg::lane_payload_t [NrLanes-1:0]  sldu_result_o,
  input  wire logic [NrLanes-1:0]                sldu_result_gnt_i
);

  localparam int unsigned WordBytes = NrLanes * sldu_pkg::LaneBytes;
  localparam int unsigned WIdx      = $clog2(WordBytes);
  localparam int unsigned PntW      = WIdx + 1;

  sldu_pkg::pe_req_t  issue_req, commit_req;
  logic               issue_valid, issue_done, commit_valid, commit_done;
  sldu_pkg::vlen_t    issue_rem, chunk_bytes, out_start, word_pos;
  logic [PntW-1:0]    in_pnt, out_pnt, byte_count, shift_bytes;
  logic               chunk, push, rq_full, word_retired;
  sldu_pkg::vaddr_t   word_index;
  sldu_pkg::lane_payload_t [NrLanes-1:0] shifted;
  sldu_pkg::pe_resp_t resp_d;

  // Idle cycles move no bytes
  assign shift_bytes = chunk ? byte_count : '0;
  assign chunk_bytes = sldu_pkg::vlen_t'(shift_bytes);

  // Output position of the chunk gives the emitted word number
  assign out_start  = (issue_req.op == sldu_pkg::SLIDE_UP) ?
                      (issue_req.stride & sldu_pkg::vlen_t'(WordBytes - 1)) : '0;
  assign word_pos   = out_start + (issue_req.vl << int'(issue_req.sew))
                    - issue_req.stride - issue_rem;
  assign word_index = sldu_pkg::vaddr_t'(word_pos >> WIdx);

  sldu_insn_queue u_insn_queue (
    .clk_i, .rst_ni,
    .req_i(pe_req_i), .req_valid_i(pe_req_valid_i), .req_ready_o(pe_req_ready_o),
    .issue_req_o(issue_req), .issue_valid_o(issue_valid), .issue_done_i(issue_done),
    .commit_req_o(commit_req), .commit_valid_o(commit_valid), .commit_done_i(commit_done)
  );

  sldu_byte_counter #(.NrLanes(NrLanes)) u_byte_counter (
    .clk_i, .rst_ni,
    .issue_load_i(issue_valid), .issue_req_i(issue_req), .chunk_bytes_i(chunk_bytes),
    .issue_rem_o(issue_rem), .commit_load_i(commit_valid), .commit_req_i(commit_req),
    .word_retired_i(word_retired), .commit_done_o(commit_done)
  );

  sldu_slide_fsm #(.NrLanes(NrLanes)) u_slide_fsm (
    .clk_i, .rst_ni,
    .issue_req_i(issue_req), .issue_valid_i(issue_valid), .issue_rem_i(issue_rem),
    .operand_valid_i(sldu_operand_valid_i), .rq_full_i(rq_full),
    .in_pnt_o(in_pnt), .out_pnt_o(out_pnt), .byte_count_o(byte_count), .chunk_o(chunk),
    .operand_ready_o(sldu_operand_ready_o), .push_o(push), .issue_done_o(issue_done)
  );

  sldu_byte_shifter #(.NrLanes(NrLanes)) u_byte_shifter (
    .operand_i(sldu_operand_i), .in_pnt_i(in_pnt), .out_pnt_i(out_pnt),
    .byte_count_i(shift_bytes), .issue_req_i(issue_req), .word_index_i(word_index),
    .payload_o(shifted)
  );

  sldu_result_queue #(
    .NrLanes(NrLanes), .payload_t(sldu_pkg::lane_payload_t)
  ) u_result_queue (
    .clk_i, .rst_ni,
    .push_i(push), .payload_i(shifted), .full_o(rq_full),
    .req_o(sldu_result_req_o), .data_o(sldu_result_o), .gnt_i(sldu_result_gnt_i),
    .word_retired_o(word_retired)
  );

  // Done bit for the committing id, one cycle late
  always_comb begin
    resp_d = '0;
    resp_d.vinsn_done[commit_req.id] = commit_done;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pe_resp_o <= '0;
    end else begin
      pe_resp_o <= resp_d;
    end
  end

endmodule

`default_nettype wire
